/* Bender.yml */
package:
  name: core_bus

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bus_pkg.sv
      - hdl/bus_arbiter.sv
      - hdl/read_lane_select.sv
      - hdl/write_lane_align.sv
      - hdl/clint_timer.sv
      - hdl/core_bus.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/axi_mem_model.sv
      - test/core_bus_tb.sv

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module bus_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  logic [`ADDR_W-1:0] ifu_araddr_i,
  input  logic               ifu_arvalid_i,
  input  logic [`ADDR_W-1:0] lsu_araddr_i,
  input  logic               lsu_arvalid_i,
  input  logic [`DATA_W/8-1:0] lsu_rstrb_i,
  input  logic               lsu_awvalid_i,
  input  logic               lsu_wvalid_i,
  input  logic               arready_i,
  input  logic               rvalid_i,
  input  logic               awready_i,
  input  logic               wready_i,
  input  logic               bvalid_i,
  input  logic               timer_rvalid_i,
  output logic [`ADDR_W-1:0] araddr_o,
  output logic [2:0]         arsize_o,
  output logic               arvalid_o,
  output logic               awvalid_o,
  output logic               wvalid_o,
  output logic               lane_hi_o,
  output logic               timer_sel_o,
  output logic               timer_req_o,
  output logic               ifu_rvalid_o,
  output logic               lsu_rvalid_o,
  output logic               lsu_wready_o
);

  // one-hot read FSM
  localparam logic [3:0] RD_IDLE  = 4'b0001;
  localparam logic [3:0] RD_IFU_D = 4'b0010;
  localparam logic [3:0] RD_LSU_A = 4'b0100;
  localparam logic [3:0] RD_LSU_D = 4'b1000;

  // store FSM
  localparam logic [2:0] ST_IDLE  = 3'b001;
  localparam logic [2:0] ST_ISSUE = 3'b010;
  localparam logic [2:0] ST_RESP  = 3'b100;

  logic [3:0]         rd_state_q;
  logic [2:0]         st_state_q;
  logic [`ADDR_W-1:0] araddr_q;
  logic               timer_sel_q;
  logic               timer_req_q;
  logic               aw_done_q;
  logic               w_done_q;

  logic               rd_idle;
  logic               lsu_is_timer;
  logic               lsu_pick;
  logic               lsu_mem_pick;
  logic               lsu_timer_pick;
  logic [2:0]         lsu_size;
  logic               aw_fire;
  logic               w_fire;

  assign rd_idle        = (rd_state_q == RD_IDLE);
  assign lsu_is_timer   = (lsu_araddr_i == `CLINT_ADDR_LO) || (lsu_araddr_i == `CLINT_ADDR_HI);
  assign lsu_pick       = lsu_arvalid_i && !ifu_arvalid_i;  // ifu has fixed priority
  assign lsu_mem_pick   = lsu_pick && !lsu_is_timer;
  assign lsu_timer_pick = lsu_pick && lsu_is_timer;

  always_comb begin
    case (lsu_rstrb_i)
      4'h1:    lsu_size = `SIZE_BYTE;
      4'h3:    lsu_size = `SIZE_HALF;
      default: lsu_size = `SIZE_WORD;
    endcase
  end

  assign arvalid_o = (rd_idle && (ifu_arvalid_i || lsu_mem_pick)) || (rd_state_q == RD_LSU_A);
  assign araddr_o  = !rd_idle ? araddr_q : (ifu_arvalid_i ? ifu_araddr_i : lsu_araddr_i);
  assign arsize_o  = (rd_idle && ifu_arvalid_i) ? `SIZE_WORD : lsu_size;

  assign lane_hi_o   = araddr_q[2];  // also picks the mtime half
  assign timer_sel_o = timer_sel_q;
  assign timer_req_o = timer_req_q;

  assign ifu_rvalid_o = (rd_state_q == RD_IFU_D) && rvalid_i;
  assign lsu_rvalid_o = (rd_state_q == RD_LSU_D) && (timer_sel_q ? timer_rvalid_i : rvalid_i);

  // chosen address tracks the request while idle
  always_ff @(posedge clk) begin
    if (rd_idle) begin
      araddr_q <= ifu_arvalid_i ? ifu_araddr_i : lsu_araddr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state_q  <= RD_IDLE;
      timer_sel_q <= 1'b0;
      timer_req_q <= 1'b0;
    end else begin
      timer_req_q <= rd_idle && lsu_timer_pick;
      if (rd_idle) begin
        timer_sel_q <= lsu_timer_pick;
      end
      case (rd_state_q)
        RD_IDLE: begin
          if (ifu_arvalid_i) begin
            if (arready_i) rd_state_q <= RD_IFU_D;
          end else if (lsu_mem_pick) begin
            rd_state_q <= arready_i ? RD_LSU_D : RD_LSU_A;
          end else if (lsu_timer_pick) begin
            rd_state_q <= RD_LSU_D;  // wait for the timer
          end
        end
        RD_IFU_D: if (rvalid_i) rd_state_q <= RD_IDLE;
        RD_LSU_A: if (arready_i) rd_state_q <= RD_LSU_D;
        RD_LSU_D: if (lsu_rvalid_o) rd_state_q <= RD_IDLE;
        default:  rd_state_q <= RD_IDLE;
      endcase
    end
  end

  assign awvalid_o    = (st_state_q == ST_ISSUE) && !aw_done_q;
  assign wvalid_o     = (st_state_q == ST_ISSUE) && !w_done_q;
  assign aw_fire      = awvalid_o && awready_i;
  assign w_fire       = wvalid_o && wready_i;
  assign lsu_wready_o = (st_state_q == ST_RESP) && bvalid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      st_state_q <= ST_IDLE;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
    end else begin
      case (st_state_q)
        ST_IDLE: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (lsu_awvalid_i && lsu_wvalid_i) st_state_q <= ST_ISSUE;
        end
        ST_ISSUE: begin
          if (aw_fire) aw_done_q <= 1'b1;
          if (w_fire) w_done_q <= 1'b1;
          // both channels done this cycle or earlier
          if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) st_state_q <= ST_RESP;
        end
        ST_RESP: if (bvalid_i) st_state_q <= ST_IDLE;
        default: st_state_q <= ST_IDLE;
      endcase
    end
  end

  // requesters hold their address, so the AR channel must too
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

  // an R beat needs a memory read waiting for it
  r_owned: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> (rd_state_q == RD_IFU_D) || (rd_state_q == RD_LSU_D && !timer_sel_q));

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

`include "bus_settings.svh"

package bus_pkg;

  // one 64-bit AXI data beat
  // lanes: two requester words, lane 1 holds address bit 2 set
  // bytes: the eight byte lanes that wstrb covers
  typedef union packed {
    logic [`BEAT_W/`DATA_W-1:0][`DATA_W-1:0] lanes;
    logic [`BEAT_W/8-1:0][7:0]               bytes;
  } beat_u;

endpackage

`default_nettype wire

/* hdl/bus_settings.svh */
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// requester side
`define ADDR_W 32
`define DATA_W 32

// one AXI data beat
`define BEAT_W 64

// machine timer word addresses, low and high half of mtime
`define CLINT_ADDR_LO 32'h0200_bff8
`define CLINT_ADDR_HI 32'h0200_bffc

// AXI size codes
`define SIZE_BYTE 3'd0
`define SIZE_HALF 3'd1
`define SIZE_WORD 3'd2

`endif

/* hdl/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module clint_timer (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_i,
  input  logic               addr_hi_i,
  output logic [`DATA_W-1:0] rdata_o,
  output logic               rvalid_o
);

  logic [2*`DATA_W-1:0] mtime_q;

  // free running from zero in the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q  <= '0;
      rvalid_o <= 1'b0;
    end else begin
      mtime_q  <= mtime_q + 1'b1;
      rvalid_o <= req_i && !rvalid_o;  // one pulse per request
    end
  end

  // current value in the response cycle
  assign rdata_o = addr_hi_i ? mtime_q[2*`DATA_W-1:`DATA_W] : mtime_q[`DATA_W-1:0];

  // every request is answered in the next cycle
  req_answered: assert property (@(posedge clk) disable iff (rst)
    req_i |=> rvalid_o);

endmodule

`default_nettype wire

/* hdl/core_bus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module core_bus (
  input  logic                 clk,
  input  logic                 rst,

  // instruction fetch
  input  logic [`ADDR_W-1:0]   ifu_araddr_i,
  input  logic                 ifu_arvalid_i,
  output logic [`DATA_W-1:0]   ifu_rdata_o,
  output logic                 ifu_rvalid_o,

  // load
  input  logic [`ADDR_W-1:0]   lsu_araddr_i,
  input  logic                 lsu_arvalid_i,
  input  logic [`DATA_W/8-1:0] lsu_rstrb_i,
  output logic [`DATA_W-1:0]   lsu_rdata_o,
  output logic                 lsu_rvalid_o,

  // store
  input  logic [`ADDR_W-1:0]   lsu_awaddr_i,
  input  logic                 lsu_awvalid_i,
  input  logic [`DATA_W-1:0]   lsu_wdata_i,
  input  logic [`DATA_W/8-1:0] lsu_wstrb_i,
  input  logic                 lsu_wvalid_i,
  output logic                 lsu_wready_o,

  // AXI4 master, single beat only
  output logic [`ADDR_W-1:0]   io_master_araddr_o,
  output logic [2:0]           io_master_arsize_o,
  output logic                 io_master_arvalid_o,
  input  logic                 io_master_arready_i,
  input  bus_pkg::beat_u       io_master_rdata_i,
  input  logic                 io_master_rvalid_i,
  output logic [`ADDR_W-1:0]   io_master_awaddr_o,
  output logic [2:0]           io_master_awsize_o,
  output logic                 io_master_awvalid_o,
  input  logic                 io_master_awready_i,
  output bus_pkg::beat_u       io_master_wdata_o,
  output logic [`BEAT_W/8-1:0] io_master_wstrb_o,
  output logic                 io_master_wlast_o,
  output logic                 io_master_wvalid_o,
  input  logic                 io_master_wready_i,
  input  logic                 io_master_bvalid_i
);

  logic               lane_hi;
  logic               timer_sel;
  logic               timer_req;
  logic               timer_rvalid;
  logic [`DATA_W-1:0] timer_rdata;
  logic [`DATA_W-1:0] rd_word;

  bus_arbiter arbiter_i (
    .clk            (clk),
    .rst            (rst),
    .ifu_araddr_i   (ifu_araddr_i),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_rstrb_i    (lsu_rstrb_i),
    .lsu_awvalid_i  (lsu_awvalid_i),
    .lsu_wvalid_i   (lsu_wvalid_i),
    .arready_i      (io_master_arready_i),
    .rvalid_i       (io_master_rvalid_i),
    .awready_i      (io_master_awready_i),
    .wready_i       (io_master_wready_i),
    .bvalid_i       (io_master_bvalid_i),
    .timer_rvalid_i (timer_rvalid),
    .araddr_o       (io_master_araddr_o),
    .arsize_o       (io_master_arsize_o),
    .arvalid_o      (io_master_arvalid_o),
    .awvalid_o      (io_master_awvalid_o),
    .wvalid_o       (io_master_wvalid_o),
    .lane_hi_o      (lane_hi),
    .timer_sel_o    (timer_sel),
    .timer_req_o    (timer_req),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_wready_o   (lsu_wready_o)
  );

  read_lane_select rd_lane_i (
    .beat_i        (io_master_rdata_i),
    .lane_hi_i     (lane_hi),
    .timer_sel_i   (timer_sel),
    .timer_rdata_i (timer_rdata),
    .rdata_o       (rd_word)
  );

  write_lane_align wr_align_i (
    .awaddr_i (lsu_awaddr_i),
    .wdata_i  (lsu_wdata_i),
    .wstrb_i  (lsu_wstrb_i),
    .wdata_o  (io_master_wdata_o),
    .wstrb_o  (io_master_wstrb_o),
    .awsize_o (io_master_awsize_o)
  );

  clint_timer clint_i (
    .clk       (clk),
    .rst       (rst),
    .req_i     (timer_req),
    .addr_hi_i (lane_hi),
    .rdata_o   (timer_rdata),
    .rvalid_o  (timer_rvalid)
  );

  // one read word, the rvalid pulses tell the owner
  assign ifu_rdata_o = rd_word;
  assign lsu_rdata_o = rd_word;

  assign io_master_awaddr_o = lsu_awaddr_i;  // held by the lsu until wready
  assign io_master_wlast_o  = io_master_wvalid_o;

endmodule

`default_nettype wire

/* hdl/read_lane_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module read_lane_select (
  input  bus_pkg::beat_u     beat_i,
  input  logic               lane_hi_i,
  input  logic               timer_sel_i,
  input  logic [`DATA_W-1:0] timer_rdata_i,
  output logic [`DATA_W-1:0] rdata_o
);

  logic [`DATA_W-1:0] lane_word;

  // lane 1 carries addresses with bit 2 set
  assign lane_word = beat_i.lanes[lane_hi_i];

  always_comb begin
    if (timer_sel_i) begin
      rdata_o = timer_rdata_i;  // mtime half, never from AXI
    end else begin
      rdata_o = lane_word;
    end
  end

endmodule

`default_nettype wire

/* hdl/write_lane_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module write_lane_align (
  input  logic [`ADDR_W-1:0]   awaddr_i,
  input  logic [`DATA_W-1:0]   wdata_i,
  input  logic [`DATA_W/8-1:0] wstrb_i,
  output bus_pkg::beat_u       wdata_o,
  output logic [`BEAT_W/8-1:0] wstrb_o,
  output logic [2:0]           awsize_o
);

  logic [1:0]           byte_off;
  logic                 lane_hi;
  logic [`DATA_W-1:0]   data_sh;
  logic [`DATA_W/8-1:0] strb_sh;

  assign byte_off = awaddr_i[1:0];
  assign lane_hi  = awaddr_i[2];

  // move bytes up to their offset inside the word
  assign data_sh = wdata_i << {byte_off, 3'b000};
  assign strb_sh = wstrb_i << byte_off;

  always_comb begin
    wdata_o = '0;
    for (int i = 0; i < `DATA_W/8; i++) begin
      wdata_o.bytes[{lane_hi, 2'(i)}] = data_sh[8*i +: 8];
    end
  end

  assign wstrb_o = lane_hi ? {strb_sh, {(`DATA_W/8){1'b0}}} : {{(`DATA_W/8){1'b0}}, strb_sh};

  always_comb begin
    case (wstrb_i)
      4'h1:    awsize_o = `SIZE_BYTE;
      4'h3:    awsize_o = `SIZE_HALF;
      default: awsize_o = `SIZE_WORD;
    endcase
  end

  // zero while no store is pending
  strb_legal: assert final ($isunknown(wstrb_i)
    || wstrb_i inside {4'h0, 4'h1, 4'h3, 4'hf});

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/bus_arbiter.sv
hdl/read_lane_select.sv
hdl/write_lane_align.sv
hdl/clint_timer.sv
hdl/core_bus.sv
test/axi_mem_model.sv
test/core_bus_tb.sv

/* test/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module axi_mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`ADDR_W-1:0]   araddr_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output bus_pkg::beat_u       rdata_o,
  output logic                 rvalid_o,
  input  logic [`ADDR_W-1:0]   awaddr_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  bus_pkg::beat_u       wdata_i,
  input  logic [`BEAT_W/8-1:0] wstrb_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output logic                 bvalid_o,
  output int                   aw_count_o,
  output int                   w_count_o
);

  logic [7:0]           mem [0:1023];  // preloaded by the testbench
  logic [31:0]          lfsr;
  int                   ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic                 rd_pend, aw_seen, w_seen, b_pend;
  logic [9:0]           rd_addr, wr_addr;
  bus_pkg::beat_u       wr_beat;
  logic [`BEAT_W/8-1:0] wr_strb;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // 0 to 3 cycles, two LFSR bits
  function automatic int draw_delay();
    int d;
    lfsr = lfsr_step(lfsr);
    d = lfsr[0];
    lfsr = lfsr_step(lfsr);
    d = d + 2 * lfsr[0];
    return d;
  endfunction

  function automatic bus_pkg::beat_u read_beat(input logic [9:0] addr);
    bus_pkg::beat_u b;
    for (int k = 0; k < `BEAT_W/8; k++) begin
      b.bytes[k] = mem[{addr[9:3], 3'(k)}];
    end
    return b;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      arready_o <= 1'b0; rvalid_o <= 1'b0; awready_o <= 1'b0;
      wready_o <= 1'b0; bvalid_o <= 1'b0; rdata_o <= '0;
      lfsr = 32'h7238;
      ar_wait = 0; r_wait = 0; aw_wait = 0; w_wait = 0; b_wait = 0;
      rd_pend = 0; aw_seen = 0; w_seen = 0; b_pend = 0;
      aw_count_o = 0;
      w_count_o = 0;
    end else begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      if (rd_pend) begin
        if (r_wait == 0) begin
          rdata_o  <= read_beat(rd_addr);
          rvalid_o <= 1'b1;
          rd_pend = 0;
        end else r_wait--;
      end
      if (arvalid_i && arready_o) begin
        arready_o <= 1'b0;
        rd_addr = araddr_i[9:0];
        rd_pend = 1;
        r_wait  = draw_delay();
        ar_wait = draw_delay();
      end else if (arvalid_i && !rd_pend) begin
        if (ar_wait == 0) arready_o <= 1'b1;
        else ar_wait--;
      end
      if (awvalid_i && awready_o) begin
        awready_o <= 1'b0;
        aw_seen = 1;
        wr_addr = awaddr_i[9:0];
        aw_count_o++;
        aw_wait = draw_delay();
      end else if (awvalid_i && !aw_seen) begin
        if (aw_wait == 0) awready_o <= 1'b1;
        else aw_wait--;
      end
      if (wvalid_i && wready_o) begin
        wready_o <= 1'b0;
        w_seen  = 1;
        wr_beat = wdata_i;
        wr_strb = wstrb_i;
        w_count_o++;
        w_wait = draw_delay();
      end else if (wvalid_i && !w_seen) begin
        if (w_wait == 0) wready_o <= 1'b1;
        else w_wait--;
      end
      if (aw_seen && w_seen && !b_pend) begin
        for (int k = 0; k < `BEAT_W/8; k++) begin
          if (wr_strb[k]) mem[{wr_addr[9:3], 3'(k)}] = wr_beat.bytes[k];
        end
        b_pend = 1;
        b_wait = draw_delay();
      end else if (b_pend) begin
        if (b_wait == 0) begin
          bvalid_o <= 1'b1;
          b_pend = 0; aw_seen = 0; w_seen = 0;
        end else b_wait--;
      end
    end
  end

endmodule

`default_nettype wire

/* test/core_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module core_bus_tb;

  logic clk, rst;
  logic [`ADDR_W-1:0] ifu_araddr, lsu_araddr, lsu_awaddr, araddr, awaddr;
  logic ifu_arvalid, lsu_arvalid, lsu_awvalid, lsu_wvalid;
  logic [`DATA_W/8-1:0] lsu_rstrb, lsu_wstrb;
  logic [`DATA_W-1:0] lsu_wdata, ifu_rdata, lsu_rdata;
  logic ifu_rvalid, lsu_rvalid, lsu_wready;
  logic [2:0] arsize, awsize;
  logic arvalid, arready, rvalid, awvalid, awready, wlast, wvalid, wready, bvalid;
  bus_pkg::beat_u rdata, wdata;
  logic [`BEAT_W/8-1:0] wstrb;
  int aw_count, w_count, cycles, stores, wready_pulses, lat;
  logic [7:0] shadow [0:1023];
  logic [63:0] since_rst;  // same count as mtime
  logic [31:0] lfsr;
  logic ifu_done;

  core_bus dut_i (
    .clk(clk), .rst(rst),
    .ifu_araddr_i(ifu_araddr), .ifu_arvalid_i(ifu_arvalid),
    .ifu_rdata_o(ifu_rdata), .ifu_rvalid_o(ifu_rvalid),
    .lsu_araddr_i(lsu_araddr), .lsu_arvalid_i(lsu_arvalid), .lsu_rstrb_i(lsu_rstrb),
    .lsu_rdata_o(lsu_rdata), .lsu_rvalid_o(lsu_rvalid),
    .lsu_awaddr_i(lsu_awaddr), .lsu_awvalid_i(lsu_awvalid), .lsu_wdata_i(lsu_wdata),
    .lsu_wstrb_i(lsu_wstrb), .lsu_wvalid_i(lsu_wvalid), .lsu_wready_o(lsu_wready),
    .io_master_araddr_o(araddr), .io_master_arsize_o(arsize),
    .io_master_arvalid_o(arvalid), .io_master_arready_i(arready),
    .io_master_rdata_i(rdata), .io_master_rvalid_i(rvalid),
    .io_master_awaddr_o(awaddr), .io_master_awsize_o(awsize),
    .io_master_awvalid_o(awvalid), .io_master_awready_i(awready),
    .io_master_wdata_o(wdata), .io_master_wstrb_o(wstrb), .io_master_wlast_o(wlast),
    .io_master_wvalid_o(wvalid), .io_master_wready_i(wready),
    .io_master_bvalid_i(bvalid)
  );

  axi_mem_model mem_i (
    .clk(clk), .rst(rst),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rvalid_o(rvalid),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
    .bvalid_o(bvalid), .aw_count_o(aw_count), .w_count_o(w_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [2:0] size_of(input logic [3:0] strb);
    return (strb == 4'h1) ? `SIZE_BYTE : (strb == 4'h3) ? `SIZE_HALF : `SIZE_WORD;
  endfunction

  // shadow memory model of expected words and stores
  function automatic logic [`DATA_W-1:0] ref_word(input logic [`ADDR_W-1:0] addr);
    logic [9:0] i;
    i = {addr[9:2], 2'b00};
    return {shadow[i + 3], shadow[i + 2], shadow[i + 1], shadow[i]};
  endfunction

  function automatic void ref_store(input logic [`ADDR_W-1:0] addr,
                                    input logic [`DATA_W-1:0] data, input logic [3:0] strb);
    for (int j = 0; j < 4; j++) begin
      if (strb[j]) shadow[addr[9:0] + j] = data[8*j +: 8];
    end
  endfunction

  function automatic bus_pkg::beat_u expected_beat(input logic [`ADDR_W-1:0] addr,
                                                   input logic [`DATA_W-1:0] data);
    bus_pkg::beat_u b;
    int k;
    b = '0;
    for (int j = 0; j < 4; j++) begin
      k = addr[1:0] + j;
      if (k < 4) b.bytes[{addr[2], 2'(k)}] = data[8*j +: 8];
    end
    return b;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [`DATA_W-1:0] exp, got);
    if (got !== exp) stop_run($sformatf("Error %s expected %h got %h", name, exp, got));
  endtask

  task automatic check_beat(input string name, input bus_pkg::beat_u exp, got);
    if (got !== exp) stop_run($sformatf("Error %s expected %h got %h", name, exp, got));
  endtask

  task automatic check_size(input string name, input logic [2:0] exp, got);
    if (got !== exp) stop_run($sformatf("Error %s expected %h got %h", name, exp, got));
  endtask

  always @(posedge clk) begin
    since_rst <= rst ? 64'd0 : since_rst + 1;
    cycles++;
    if (cycles > 4000) stop_run("timeout, no finish within 4000 cycles");
  end

  // compare process
  always @(negedge clk) begin
    if (!rst) begin
      if (ifu_rvalid && lsu_rvalid) stop_run("ifu and lsu read responses in the same cycle");
      if (ifu_rvalid) check_word("ifu_rdata_o", ref_word(ifu_araddr), ifu_rdata);
      if (lsu_rvalid) begin
        if (lsu_araddr == `CLINT_ADDR_LO)
          check_word("lsu_rdata_o", since_rst[31:0], lsu_rdata);
        else if (lsu_araddr == `CLINT_ADDR_HI)
          check_word("lsu_rdata_o", since_rst[63:32], lsu_rdata);
        else
          check_word("lsu_rdata_o", ref_word(lsu_araddr), lsu_rdata);
      end
      if (arvalid) begin
        if (!ifu_arvalid && (lsu_araddr == `CLINT_ADDR_LO || lsu_araddr == `CLINT_ADDR_HI))
          stop_run("timer read reached the AXI read channel");
        check_word("io_master_araddr_o", ifu_arvalid ? ifu_araddr : lsu_araddr, araddr);
        check_size("io_master_arsize_o", ifu_arvalid ? `SIZE_WORD : size_of(lsu_rstrb), arsize);
      end
      if (awvalid) begin
        check_word("io_master_awaddr_o", lsu_awaddr, awaddr);
        check_size("io_master_awsize_o", size_of(lsu_wstrb), awsize);
      end
      if (wvalid) begin
        check_beat("io_master_wdata_o", expected_beat(lsu_awaddr, lsu_wdata), wdata);
        check_word("io_master_wstrb_o", 32'(8'(lsu_wstrb) << lsu_awaddr[2:0]), 32'(wstrb));
        check_word("io_master_wlast_o", 32'd1, 32'(wlast));
      end
      if (lsu_wready) wready_pulses++;
    end
  end

  task automatic ifu_read(input logic [`ADDR_W-1:0] addr);
    @(posedge clk);
    #5 ifu_araddr = addr;
    ifu_arvalid = 1'b1;
    @(negedge clk);
    while (!ifu_rvalid) @(negedge clk);
    @(posedge clk);
    #5 ifu_arvalid = 1'b0;
  endtask

  task automatic lsu_read(input logic [`ADDR_W-1:0] addr, input logic [3:0] strb,
                          output int latency);
    @(posedge clk);
    #5 lsu_araddr = addr;
    lsu_rstrb = strb;
    lsu_arvalid = 1'b1;
    latency = 0;
    @(negedge clk);
    while (!lsu_rvalid) begin
      latency++;
      @(negedge clk);
    end
    @(posedge clk);
    #5 lsu_arvalid = 1'b0;
    lsu_rstrb = '0;
  endtask

  task automatic lsu_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data,
                           input logic [3:0] strb);
    @(posedge clk);
    #5 lsu_awaddr = addr;
    lsu_wdata = data;
    lsu_wstrb = strb;
    lsu_awvalid = 1'b1;
    lsu_wvalid = 1'b1;
    @(negedge clk);
    while (!lsu_wready) @(negedge clk);
    ref_store(addr, data, strb);
    stores++;
    @(posedge clk);
    #5 lsu_awvalid = 1'b0;
    lsu_wvalid = 1'b0;
    lsu_wstrb = '0;
  endtask

  initial begin
    rst = 1'b1;
    ifu_araddr = '0;
    ifu_arvalid = 1'b0;
    lsu_araddr = '0;
    lsu_arvalid = 1'b0;
    lsu_rstrb = '0;
    lsu_awaddr = '0;
    lsu_awvalid = 1'b0;
    lsu_wdata = '0;
    lsu_wstrb = '0;
    lsu_wvalid = 1'b0;
    lfsr = 32'h7238;
    cycles = 0;
    stores = 0;
    wready_pulses = 0;
    ifu_done = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = 8'(i * 13) ^ 8'(i >> 4);
      mem_i.mem[i] = shadow[i];
    end
    repeat (2) @(posedge clk);
    #5 rst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      if (arvalid || awvalid || wvalid || ifu_rvalid || lsu_rvalid || lsu_wready)
        stop_run("control output high after reset before any request");
    end
    ifu_read(32'h8000_0040);
    ifu_read(32'h8000_0044);
    ifu_read(32'h8000_03bc);
    for (int off = 0; off < 8; off++) begin
      lsu_write(32'h8000_0100 + off, lfsr_bits(32), 4'h1);
      lsu_read(32'h8000_0100 + off, 4'h1, lat);
    end
    for (int off = 0; off < 8; off += 2) begin
      lsu_write(32'h8000_0108 + off, lfsr_bits(32), 4'h3);
      lsu_read(32'h8000_0108 + off, 4'h3, lat);
    end
    for (int off = 0; off < 8; off += 4) begin
      lsu_write(32'h8000_0110 + off, lfsr_bits(32), 4'hf);
      lsu_read(32'h8000_0110 + off, 4'hf, lat);
    end
    lsu_read(`CLINT_ADDR_LO, 4'hf, lat);
    check_word("timer lsu_rvalid_o delay", 32'd2, 32'(lat));
    lsu_read(`CLINT_ADDR_HI, 4'hf, lat);
    check_word("timer lsu_rvalid_o delay", 32'd2, 32'(lat));
    fork
      begin
        ifu_read(32'h8000_0080);
        ifu_done = 1'b1;
      end
      begin
        lsu_read(32'h8000_0088, 4'hf, lat);
        if (!ifu_done) stop_run("lsu read served before the ifu read raised with it");
      end
    join
    fork
      for (int i = 0; i < 10; i++) lsu_write(32'h8000_0200 + 4 * lfsr_bits(5),
                                            lfsr_bits(32), 4'hf);
      for (int i = 0; i < 10; i++) ifu_read(32'h8000_0300 + 4 * lfsr_bits(5));
    join
    for (int i = 0; i < 8; i++) lsu_read(32'h8000_0200 + 16 * i, 4'hf, lat);
    check_word("aw acceptances", 32'(stores), 32'(aw_count));
    check_word("w acceptances", 32'(stores), 32'(w_count));
    check_word("lsu_wready_o pulses", 32'(stores), 32'(wready_pulses));
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
